//--- vlog.f
mem_sys_pkg.sv
cache_way.sv
four_bank_mem.sv
cache_ctrl.sv
mem_system.sv
tb_clkgen.sv
tb_mem_system.sv

//--- run.sh
#!/bin/sh
# Build and run the cache memory system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_mem_system -f vlog.f -o sim_mem_system
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_mem_system)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
	exit 0
else
	exit 1
fi

//--- tb_mem_system.sv
/*
 * Testbench for the two-way cache memory system.
 * A reference model predicts data_out, cache_hit and err for
 * every request; a compare process checks them in the done cycle
 */
`default_nettype none

module tb_mem_system;

	timeunit 1ns;
	timeprecision 100ps;

	logic        clk;
	logic        arst_n;
	logic [15:0] addr;
	logic [15:0] data_in;
	logic        rd;
	logic        wr;
	logic [15:0] data_out;
	logic        done;
	logic        stall;
	logic        cache_hit;
	logic        err;

	// Reference model state
	logic [15:0] mem_model [32768];
	logic [4:0]  tag_m [256][2];
	logic        valid_m [256][2];
	logic        lru_m [256];

	// Expected response of the request in flight
	string       cur_name;
	logic        exp_err;
	logic        exp_hit;
	logic        exp_rd;
	logic [15:0] exp_data;
	int          req_cnt;
	int          done_cnt;
	int          n_checks;
	int          n_errors;
	int          chk0;
	int          err0;
	logic        timed_out;
	integer      seed;

	tb_clkgen #(
		.period_ns    (4),
		.reset_cycles (3)
	) i_clkgen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	mem_system #(
		.bank_cycles (4)
	) i_dut (
		.clk       (clk),
		.arst_n    (arst_n),
		.addr      (addr),
		.data_in   (data_in),
		.rd        (rd),
		.wr        (wr),
		.data_out  (data_out),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err)
	);

	function automatic logic [15:0] make_addr(input logic [4:0] tag, input logic [7:0] set,
		input logic [1:0] word);
		return {tag, set, word, 1'b0};
	endfunction

	// Returns {err, hit, data} and advances the model
	function automatic logic [17:0] predict(input logic r, input logic w,
		input logic [15:0] a, input logic [15:0] d);
		logic [4:0] t;
		logic [7:0] s;
		logic       hit_v;
		logic       way;
		t = a[15:11];
		s = a[10:3];
		if (a[0] || (r && w))
			return {1'b1, 1'b0, 16'h0000};    // Illegal, nothing changes
		hit_v = 1'b0;
		way   = 1'b0;
		if (valid_m[s][0] && tag_m[s][0] == t) begin
			hit_v = 1'b1;
		end else if (valid_m[s][1] && tag_m[s][1] == t) begin
			hit_v = 1'b1;
			way   = 1'b1;
		end else begin
			if (!valid_m[s][0])
				way = 1'b0;
			else if (!valid_m[s][1])
				way = 1'b1;
			else
				way = lru_m[s];
			tag_m[s][way]   = t;
			valid_m[s][way] = 1'b1;
		end
		lru_m[s] = ~way;
		if (w)
			mem_model[a[15:1]] = d;
		return {1'b0, hit_v, mem_model[a[15:1]]};
	endfunction

	task automatic check(input string name, input logic [15:0] expected, input logic [15:0] actual);
		n_checks++;
		if (expected !== actual) begin
			n_errors++;
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic access(input string name, input logic r, input logic w,
		input logic [15:0] a, input logic [15:0] d);
		logic [17:0] expv;
		int          cnt;
		logic        got;
		if (timed_out)
			return;
		@(negedge clk);
		expv     = predict(r, w, a, d);
		exp_err  = expv[17];
		exp_hit  = expv[16];
		exp_data = expv[15:0];
		exp_rd   = r & ~expv[17];
		cur_name = name;
		req_cnt++;
		addr     = a;
		data_in  = d;
		rd       = r;
		wr       = w;
		cnt = 0;
		got = 1'b0;
		while (!got && cnt < 200) begin
			@(negedge clk);
			got = done;
			cnt++;
		end
		if (!got) begin
			$display("ERROR: %s: no done within timeout", name);
			timed_out = 1'b1;
		end else if (exp_err || exp_hit) begin
			check({name, " latency"}, 16'd2, 16'(cnt));    // Hits and errors take two cycles
		end
		@(negedge clk);    // Request held through the done edge
		rd = 1'b0;
		wr = 1'b0;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, n_checks - chk0, n_errors - err0);
		chk0 = n_checks;
		err0 = n_errors;
	endtask

	// Checks each response in the middle of the done cycle
	always @(negedge clk) begin
		if (arst_n && done) begin
			if (req_cnt == done_cnt) begin
				n_errors++;
				$display("ERROR: done raised with no request pending");
			end else begin
				check({cur_name, " err"}, {15'b0, exp_err}, {15'b0, err});
				check({cur_name, " cache_hit"}, {15'b0, exp_hit}, {15'b0, cache_hit});
				check({cur_name, " stall"}, 16'h0001, {15'b0, stall});
				if (exp_rd)
					check({cur_name, " data_out"}, exp_data, data_out);
				done_cnt++;
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [31:0] d;
		logic [15:0] a;
		int          cnt;
		addr      = '0;
		data_in   = '0;
		rd        = 1'b0;
		wr        = 1'b0;
		req_cnt   = 0;
		done_cnt  = 0;
		n_checks  = 0;
		n_errors  = 0;
		chk0      = 0;
		err0      = 0;
		timed_out = 1'b0;
		seed      = 32'h1e44f614;
		for (int i = 0; i < 32768; i++)
			mem_model[i] = '0;
		for (int s = 0; s < 256; s++) begin
			valid_m[s][0] = 1'b0;
			valid_m[s][1] = 1'b0;
			tag_m[s][0]   = '0;
			tag_m[s][1]   = '0;
			lru_m[s]      = 1'b0;
		end

		cnt = 0;
		while (!arst_n && cnt < 20) begin
			@(negedge clk);
			cnt++;
		end
		if (!arst_n) begin
			$display("ERROR: reset was never released");
			timed_out = 1'b1;
		end

		access("basic", 1'b0, 1'b1, make_addr(3, 10, 1), 16'h1234);
		access("basic", 1'b1, 1'b0, make_addr(3, 10, 1), 16'h0000);
		access("basic", 1'b1, 1'b0, make_addr(3, 10, 2), 16'h0000);
		access("basic", 1'b1, 1'b0, make_addr(7, 20, 2), 16'h0000);
		end_test("basic");

		// Order A B A C A B within one set
		access("lru", 1'b1, 1'b0, make_addr(1, 40, 0), 16'h0000);
		access("lru", 1'b1, 1'b0, make_addr(2, 40, 0), 16'h0000);
		access("lru", 1'b1, 1'b0, make_addr(1, 40, 0), 16'h0000);
		access("lru", 1'b1, 1'b0, make_addr(3, 40, 0), 16'h0000);
		access("lru", 1'b1, 1'b0, make_addr(1, 40, 0), 16'h0000);
		access("lru", 1'b1, 1'b0, make_addr(2, 40, 0), 16'h0000);
		end_test("lru");

		access("dirty", 1'b0, 1'b1, make_addr(4, 77, 0), 16'ha001);
		access("dirty", 1'b0, 1'b1, make_addr(5, 77, 1), 16'ha002);
		access("dirty", 1'b0, 1'b1, make_addr(6, 77, 2), 16'ha003);    // Evicts tag 4
		access("dirty", 1'b1, 1'b0, make_addr(4, 77, 0), 16'h0000);
		access("dirty", 1'b1, 1'b0, make_addr(5, 77, 1), 16'h0000);
		access("dirty", 1'b1, 1'b0, make_addr(6, 77, 2), 16'h0000);
		access("dirty", 1'b1, 1'b0, make_addr(4, 77, 3), 16'h0000);
		end_test("dirty");

		access("illegal", 1'b0, 1'b1, make_addr(9, 100, 0), 16'h5a5a);
		access("illegal", 1'b0, 1'b1, make_addr(9, 100, 0) | 16'h0001, 16'hffff);
		access("illegal", 1'b1, 1'b1, make_addr(9, 100, 0), 16'h0bad);
		access("illegal", 1'b1, 1'b0, make_addr(9, 100, 1) | 16'h0001, 16'h0000);
		access("illegal", 1'b1, 1'b0, make_addr(9, 100, 0), 16'h0000);
		end_test("illegal");

		// Four sets, eight tags, even addresses only
		for (int i = 0; i < 300; i++) begin
			r = $random(seed);
			d = $random(seed);
			a = make_addr({2'b00, r[6:4]}, {6'b101000, r[1:0]}, r[3:2]);
			access("random", ~r[8], r[8], a, d[15:0]);
		end
		end_test("random");

		$display("checks %0d, errors %0d, timeout %0d", n_checks, n_errors, timed_out);
		if (n_errors == 0 && !timed_out)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_clkgen.sv
/*
 * Testbench clock and reset generator.
 * Free-running clock, arst_n held low for the first cycles
 */
`default_nettype none

module tb_clkgen #(
	parameter int period_ns    = 4,
	parameter int reset_cycles = 3
) (
	output logic clk,
	output logic arst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);    // Release away from the active edge
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- mem_system.sv
/*
 * Two-way set-associative write-back cache in front of the banked
 * main memory. Picks the active way, keeps one LRU bit per set
 * and holds the critical word of a read miss
 */
`default_nettype none

module mem_system #(
	parameter int bank_cycles = 4
) (
	input  wire         clk,
	input  wire         arst_n,
	input  wire  [15:0] addr,
	input  wire  [15:0] data_in,
	input  wire         rd,
	input  wire         wr,
	output logic [15:0] data_out,
	output logic        done,
	output logic        stall,
	output logic        cache_hit,
	output logic        err
);

	localparam int sets = 1 << mem_sys_pkg::index_w;

	mem_sys_pkg::mem_addr_u req_a;

	logic [mem_sys_pkg::tag_w-1:0]    tag0, tag1, tag_out;
	logic [mem_sys_pkg::word_w-1:0]   rdata0, rdata1, way_rdata, way_wdata;
	logic [mem_sys_pkg::offset_w-1:0] offset;
	logic                             hit0, hit1, hit;
	logic                             valid0, valid1, valid;
	logic                             dirty0, dirty1, dirty;
	logic                             compare, write_en, set_valid;
	logic                             fill_sel, crit_sel;
	logic                             active_way, victim;
	logic [15:0]                      mem_addr, mem_rdata;
	logic                             mem_rd, mem_wr, mem_stall;
	logic [sets-1:0]                  lru_q;
	logic [15:0]                      crit_q;

	assign req_a = addr;

	cache_way i_way0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.index     (req_a.cache_f.index),
		.offset    (offset),
		.tag_in    (req_a.cache_f.tag),
		.wdata     (way_wdata),
		.write_en  (write_en & ~active_way),
		.compare   (compare),
		.set_valid (set_valid),
		.tag_out   (tag0),
		.rdata     (rdata0),
		.hit       (hit0),
		.valid     (valid0),
		.dirty     (dirty0)
	);

	cache_way i_way1 (
		.clk       (clk),
		.arst_n    (arst_n),
		.index     (req_a.cache_f.index),
		.offset    (offset),
		.tag_in    (req_a.cache_f.tag),
		.wdata     (way_wdata),
		.write_en  (write_en & active_way),
		.compare   (compare),
		.set_valid (set_valid),
		.tag_out   (tag1),
		.rdata     (rdata1),
		.hit       (hit1),
		.valid     (valid1),
		.dirty     (dirty1)
	);

	cache_ctrl i_ctrl (
		.clk       (clk),
		.arst_n    (arst_n),
		.addr      (addr),
		.rd        (rd),
		.wr        (wr),
		.hit       (hit),
		.valid     (valid),
		.dirty     (dirty),
		.tag_out   (tag_out),
		.mem_stall (mem_stall),
		.done      (done),
		.stall     (stall),
		.cache_hit (cache_hit),
		.err       (err),
		.offset    (offset),
		.compare   (compare),
		.write_en  (write_en),
		.set_valid (set_valid),
		.fill_sel  (fill_sel),
		.crit_sel  (crit_sel),
		.mem_addr  (mem_addr),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr)
	);

	four_bank_mem #(
		.bank_cycles (bank_cycles)
	) i_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.addr   (mem_addr),
		.wdata  (way_rdata),    // Write-back data from the victim
		.rd     (mem_rd),
		.wr     (mem_wr),
		.rdata  (mem_rdata),
		.stall  (mem_stall)
	);

	// First invalid way, else the way the LRU bit names
	assign victim     = (valid0 & valid1) ? lru_q[req_a.cache_f.index] : valid0;
	assign hit        = hit0 | hit1;
	assign active_way = hit ? hit1 : victim;

	assign tag_out   = active_way ? tag1 : tag0;
	assign valid     = active_way ? valid1 : valid0;
	assign dirty     = active_way ? dirty1 : dirty0;
	assign way_rdata = active_way ? rdata1 : rdata0;

	assign way_wdata = fill_sel ? mem_rdata : data_in;
	assign data_out  = crit_sel ? crit_q : way_rdata;

	// Requested word as it comes in during the fill
	always_ff @(posedge clk) begin
		if (fill_sel && (offset[2:1] == req_a.cache_f.offset[2:1]))
			crit_q <= mem_rdata;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			lru_q <= '0;
		else if (done && !err)
			lru_q[req_a.cache_f.index] <= ~active_way;    // Point at the unused way
	end

endmodule

`default_nettype wire

//--- cache_ctrl.sv
/*
 * Cache controller FSM. Finishes hits in compare, on a miss writes
 * back a dirty victim and refills the line, overlapping the reads
 * across banks. Also flags illegal requests
 */
`default_nettype none

module cache_ctrl (
	input  wire                                 clk,
	input  wire                                 arst_n,
	input  wire  [15:0]                         addr,
	input  wire                                 rd,
	input  wire                                 wr,
	input  wire                                 hit,
	input  wire                                 valid,
	input  wire                                 dirty,
	input  wire  [mem_sys_pkg::tag_w-1:0]       tag_out,
	input  wire                                 mem_stall,
	output logic                                done,
	output logic                                stall,
	output logic                                cache_hit,
	output logic                                err,
	output logic [mem_sys_pkg::offset_w-1:0]    offset,
	output logic                                compare,
	output logic                                write_en,
	output logic                                set_valid,
	output logic                                fill_sel,
	output logic                                crit_sel,
	output logic [15:0]                         mem_addr,
	output logic                                mem_rd,
	output logic                                mem_wr
);

	localparam int cnt_w = $clog2(mem_sys_pkg::words_per_line);
	localparam logic [cnt_w-1:0] last_word = cnt_w'(mem_sys_pkg::words_per_line - 1);

	mem_sys_pkg::ctrl_state_e state, next_state;
	mem_sys_pkg::mem_addr_u   req_a, mem_a;

	logic [cnt_w-1:0] issue_cnt;
	logic [cnt_w-1:0] inst_cnt;
	logic [1:0]       rd_pipe;    // Accepted reads on their way out of memory
	logic             hit_q;
	logic             err_q;
	logic             illegal;
	logic             installing;

	assign req_a   = addr;
	assign illegal = req_a.cache_f.offset[0] | (rd & wr);

	// Read data lands two cycles after the accepted strobe
	assign installing = rd_pipe[1];

	assign mem_wr = (state == mem_sys_pkg::wb_req) & ~mem_stall;
	assign mem_rd = (state == mem_sys_pkg::fill_req) & ~mem_stall;

	always_comb begin
		mem_a = req_a;
		mem_a.cache_f.offset = {issue_cnt, 1'b0};
		if (state == mem_sys_pkg::wb_req)
			mem_a.cache_f.tag = tag_out;    // Victim line address
		mem_addr = mem_a;
	end

	always_comb begin
		if (installing)
			offset = {inst_cnt, 1'b0};
		else if (state == mem_sys_pkg::wb_req)
			offset = {issue_cnt, 1'b0};
		else
			offset = req_a.cache_f.offset;
	end

	assign compare   = (state == mem_sys_pkg::compare) | (state == mem_sys_pkg::install);
	assign fill_sel  = installing;
	assign set_valid = installing & (inst_cnt == last_word);
	assign write_en  = installing
		| ((state == mem_sys_pkg::compare) & hit & wr & ~illegal)
		| ((state == mem_sys_pkg::install) & wr);

	assign done      = (state == mem_sys_pkg::done);
	assign stall     = (state != mem_sys_pkg::idle);
	assign cache_hit = done & hit_q;
	assign err       = done & err_q;
	assign crit_sel  = done & ~hit_q & ~err_q & rd;

	always_comb begin
		next_state = state;
		case (state)
			mem_sys_pkg::idle:
				if (rd | wr)
					next_state = mem_sys_pkg::compare;
			mem_sys_pkg::compare:
				if (illegal || hit)
					next_state = mem_sys_pkg::done;
				else if (valid && dirty)
					next_state = mem_sys_pkg::wb_req;
				else
					next_state = mem_sys_pkg::fill_req;
			mem_sys_pkg::wb_req:
				if (mem_wr && (issue_cnt == last_word))
					next_state = mem_sys_pkg::wb_wait;
			mem_sys_pkg::wb_wait:
				if (!mem_stall)    // First fill bank free again
					next_state = mem_sys_pkg::fill_req;
			mem_sys_pkg::fill_req:
				if (mem_rd && (issue_cnt == last_word))
					next_state = mem_sys_pkg::fill_wait;
			mem_sys_pkg::fill_wait:
				if (set_valid)
					next_state = mem_sys_pkg::install;
			mem_sys_pkg::install:
				next_state = mem_sys_pkg::done;
			default:
				next_state = mem_sys_pkg::idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= mem_sys_pkg::idle;
			issue_cnt <= '0;
			inst_cnt  <= '0;
			rd_pipe   <= '0;
			hit_q     <= 1'b0;
			err_q     <= 1'b0;
		end else begin
			state   <= next_state;
			rd_pipe <= {rd_pipe[0], mem_rd};
			if (state == mem_sys_pkg::compare) begin
				issue_cnt <= '0;
				inst_cnt  <= '0;
				hit_q     <= hit & ~illegal;
				err_q     <= illegal;
			end else begin
				if (mem_rd || mem_wr)
					issue_cnt <= issue_cnt + 1'b1;    // Wraps to 0 after write-back
				if (installing)
					inst_cnt <= inst_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- four_bank_mem.sv
/*
 * Slow main memory split into four word-interleaved banks.
 * Each bank stays busy for bank_cycles after an access, reads
 * return through a two-stage output register
 */
`default_nettype none

module four_bank_mem #(
	parameter int bank_cycles = 4
) (
	input  wire         clk,
	input  wire         arst_n,
	input  wire  [15:0] addr,
	input  wire  [15:0] wdata,
	input  wire         rd,
	input  wire         wr,
	output logic [15:0] rdata,
	output logic        stall
);

	localparam int banks  = 4;
	localparam int rows   = 8192;
	localparam int cnt_w  = $clog2(bank_cycles + 1);

	mem_sys_pkg::mem_addr_u a;

	logic [15:0]      bank_mem [banks][rows];
	logic [cnt_w-1:0] busy_cnt [banks];
	logic [banks-1:0] busy;
	logic             accept;
	logic [15:0]      stage_q;
	logic             stage_v;

	assign a = addr;

	initial begin
		for (int b = 0; b < banks; b++) begin
			for (int r = 0; r < rows; r++)
				bank_mem[b][r] = '0;
		end
	end

	always_comb begin
		for (int b = 0; b < banks; b++)
			busy[b] = (busy_cnt[b] != '0);
	end

	assign stall  = busy[a.bank_f.bank];
	assign accept = (rd | wr) & ~stall;    // Strobe into a busy bank is dropped

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int b = 0; b < banks; b++)
				busy_cnt[b] <= '0;
			stage_v <= 1'b0;
		end else begin
			for (int b = 0; b < banks; b++) begin
				if (accept && (a.bank_f.bank == b))
					busy_cnt[b] <= cnt_w'(bank_cycles);
				else if (busy[b])
					busy_cnt[b] <= busy_cnt[b] - 1'b1;
			end
			stage_v <= rd & accept;
		end
	end

	// rdata holds until the next read reaches the second stage
	always @(posedge clk) begin
		if (rd && accept)
			stage_q <= bank_mem[a.bank_f.bank][a.bank_f.row];
		if (stage_v)
			rdata <= stage_q;
		if (wr && accept)
			bank_mem[a.bank_f.bank][a.bank_f.row] <= wdata;
	end

endmodule

`default_nettype wire

//--- cache_way.sv
/*
 * One way of the cache: tag, valid and dirty per set plus the
 * line data. Reads are combinational, writes happen on the clock
 */
`default_nettype none

module cache_way (
	input  wire                                 clk,
	input  wire                                 arst_n,
	input  wire [mem_sys_pkg::index_w-1:0]      index,
	input  wire [mem_sys_pkg::offset_w-1:0]     offset,
	input  wire [mem_sys_pkg::tag_w-1:0]        tag_in,
	input  wire [mem_sys_pkg::word_w-1:0]       wdata,
	input  wire                                 write_en,
	input  wire                                 compare,
	input  wire                                 set_valid,
	output logic [mem_sys_pkg::tag_w-1:0]       tag_out,
	output logic [mem_sys_pkg::word_w-1:0]      rdata,
	output logic                                hit,
	output logic                                valid,
	output logic                                dirty
);

	localparam int sets  = 1 << mem_sys_pkg::index_w;
	localparam int depth = sets * mem_sys_pkg::words_per_line;
	localparam int wsel_w = $clog2(mem_sys_pkg::words_per_line);

	logic [mem_sys_pkg::tag_w-1:0]  tag_mem [sets];
	logic [mem_sys_pkg::word_w-1:0] data_mem [depth];
	logic [sets-1:0]                valid_q;
	logic [sets-1:0]                dirty_q;
	logic [$clog2(depth)-1:0]       word_addr;

	// Byte offset bit 0 never selects a word
	assign word_addr = {index, offset[wsel_w:1]};

	assign tag_out = tag_mem[index];
	assign rdata   = data_mem[word_addr];
	assign valid   = valid_q[index];
	assign dirty   = dirty_q[index];
	assign hit     = valid & (tag_out == tag_in);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (write_en) begin
			if (compare) begin
				dirty_q[index] <= 1'b1;    // Requester write
			end else begin
				dirty_q[index] <= 1'b0;    // Fill from memory
				if (set_valid)
					valid_q[index] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (write_en) begin
			data_mem[word_addr] <= wdata;
			if (!compare)
				tag_mem[index] <= tag_in;
		end
	end

endmodule

`default_nettype wire

//--- mem_sys_pkg.sv
/*
 * Shared definitions for the two-way cache memory system:
 * address geometry, the two address decodings and the
 * miss controller state encoding
 */
`default_nettype none

package mem_sys_pkg;

	localparam int word_w         = 16;
	localparam int tag_w          = 5;
	localparam int index_w        = 8;
	localparam int offset_w       = 3;
	localparam int words_per_line = 4;

	// One 16-bit byte address, seen by the cache or by the banked memory
	typedef union packed {
		struct packed {
			logic [tag_w-1:0]    tag;
			logic [index_w-1:0]  index;
			logic [offset_w-1:0] offset;
		} cache_f;
		struct packed {
			logic [12:0] row;
			logic [1:0]  bank;       // Consecutive words rotate banks
			logic        byte_sel;
		} bank_f;
	} mem_addr_u;

	typedef enum logic [2:0] {
		idle,
		compare,
		wb_req,
		wb_wait,
		fill_req,
		fill_wait,
		install,
		done
	} ctrl_state_e;

endpackage

`default_nettype wire
